// ==== project.f ====
logic/switch_map_pkg.sv
logic/switch_txn_pkg.sv
logic/switch_ifc.sv
logic/source_decode.sv
logic/switch_execute.sv
logic/response_return.sv
logic/p_switch_top.sv
verification/switch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the switch testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --top-module switch_tb -f project.f \
    -Mdir obj_dir -o switch_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/switch_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Some tests failed" "$sim_log"; then
    exit 1
fi
if ! grep -q "All tests passed" "$sim_log"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// ==== verification/switch_tb.sv ====
`timescale 1ns/1ps

module switch_tb;

    localparam int SC      = 3;                            // Sources on the DUT
    localparam int TC      = switch_map_pkg::TARGET_COUNT;
    localparam int AW      = switch_map_pkg::ADDR_W;
    localparam int DW      = switch_txn_pkg::DATA_W;
    localparam int SW      = switch_txn_pkg::STRB_W;
    localparam int ZW      = switch_txn_pkg::SIZE_W;
    localparam int TIMEOUT = 200;                          // Clocks allowed per wait

    // Target model answers with the offset scrambled by a per-target key
    localparam logic [DW-1:0] TGT_KEY [TC] = '{32'h5A5A_0000, 32'h0F0F_F000,
                                               32'h3C3C_0A00, 32'hC3C3_00F0};

    typedef struct {
        string         name;
        int            grp;    // Rows of one group start in the same cycle
        int            src;
        logic          rw;
        logic [AW-1:0] addr;
        logic [DW-1:0] wdata;
        logic [SW-1:0] wstrb;
        logic [ZW-1:0] size;
        logic          abort;  // Source gives up before the answer
        int            hold;   // Clocks valid stays up before the abort
    } row_t;

    logic             clk;
    logic             reset       = 1'b1;
    logic [SC-1:0]    src_valid   = '0;
    logic [SC-1:0]    src_rw      = '0;
    logic [SC*AW-1:0] src_addr    = '0;
    logic [SC*DW-1:0] src_wdata   = '0;
    logic [SC*SW-1:0] src_wstrb   = '0;
    logic [SC*ZW-1:0] src_size    = '0;
    logic [SC-1:0]    src_ready;
    logic [SC*DW-1:0] src_rdata;
    logic [SC-1:0]    src_denied;
    logic [SC-1:0]    src_corrupt;
    logic [TC-1:0]    tgt_ready   = '0;
    logic [TC*DW-1:0] tgt_rdata   = '0;
    logic [TC-1:0]    tgt_denied  = '0;
    logic [TC-1:0]    tgt_corrupt = '0;
    logic [TC-1:0]    tgt_valid;
    logic [TC-1:0]    tgt_rw;
    logic [TC*AW-1:0] tgt_addr;
    logic [TC*DW-1:0] tgt_wdata;
    logic [TC*SW-1:0] tgt_wstrb;
    logic [TC*ZW-1:0] tgt_size;

    row_t rows [$];                 // Stimulus table
    int   owner [TC];               // Source whose request sits at a target, -1 when free
    int   wait_cnt [TC];            // Target model answer delay
    int   errors     = 0;
    int   checks     = 0;
    logic seen_three = 1'b0;        // Three target valids up at once

    p_switch_top #(.SOURCE_COUNT(SC)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    // Last resort against a stuck run
    initial begin
        repeat (5000) @(posedge clk);
        $display("Run did not finish within 5000 clocks");
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////
    // Target model
    //////////////////////////////

    always @(negedge clk) begin
        logic [1:0]    tx;
        logic [AW-1:0] off;
        for (int t = 0; t < TC; t++) begin
            tx = 2'(t);
            if (reset || !tgt_valid[tx]) begin
                tgt_ready[tx] = 1'b0;                  // Ready follows valid down
                wait_cnt[t]   = -1;
            end else if (!tgt_ready[tx]) begin
                if (wait_cnt[t] < 0) begin
                    wait_cnt[t] = int'($urandom % 4);  // Random answer delay, 1 to 4 clocks
                end else if (wait_cnt[t] == 0) begin
                    off                   = tgt_addr[t*AW +: AW];
                    tgt_rdata[t*DW +: DW] = off ^ TGT_KEY[t];
                    tgt_denied[tx]        = off[2];
                    tgt_corrupt[tx]       = off[3];
                    tgt_ready[tx]         = 1'b1;
                end else begin
                    wait_cnt[t]--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if ($countones(tgt_valid) >= 3) begin
            seen_three <= 1'b1;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic note_timeout(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic add_row(input string name, input int grp, input int src, input logic rw,
                           input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                           input logic [SW-1:0] wstrb, input logic [ZW-1:0] size,
                           input logic abort, input int hold);
        row_t r;
        r.name  = name;
        r.grp   = grp;
        r.src   = src;
        r.rw    = rw;
        r.addr  = addr;
        r.wdata = wdata;
        r.wstrb = wstrb;
        r.size  = size;
        r.abort = abort;
        r.hold  = hold;
        rows.push_back(r);
    endtask

    // One source transaction from request to the end of its hold phase
    task automatic run_txn(input int r);
        row_t          row;
        logic [1:0]    s;
        logic [1:0]    t;
        logic [AW-1:0] off;
        int            n;
        row = rows[r];
        s   = 2'(row.src);
        t   = row.addr[AW-1 -: 2];                    // Region names the target
        off = row.addr & 32'h3FFF_FFFF;
        src_rw[s]                   = row.rw;
        src_addr[row.src*AW +: AW]  = row.addr;
        src_wdata[row.src*DW +: DW] = row.wdata;
        src_wstrb[row.src*SW +: SW] = row.wstrb;
        src_size[row.src*ZW +: ZW]  = row.size;
        src_valid[s]                = 1'b1;
        n = 0;
        while (!(tgt_valid[t] && tgt_addr[t*AW +: AW] == off) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!tgt_valid[t] || tgt_addr[t*AW +: AW] != off) begin
            note_timeout({row.name, " request never reached its target"});
            src_valid[s] = 1'b0;
            return;
        end
        // A second request must not reach a target whose first source still waits
        check_val({row.name, " free target"}, 32'hFFFF_FFFF, 32'(owner[t]));
        owner[t] = row.src;
        check_val({row.name, " rw"}, 32'(row.rw), 32'(tgt_rw[t]));
        check_val({row.name, " wdata"}, row.wdata, tgt_wdata[t*DW +: DW]);
        check_val({row.name, " wstrb"}, 32'(row.wstrb), 32'(tgt_wstrb[t*SW +: SW]));
        check_val({row.name, " size"}, 32'(row.size), 32'(tgt_size[t*ZW +: ZW]));
        if (row.abort) begin
            repeat (row.hold) @(negedge clk);
            src_valid[s] = 1'b0;
            n = 0;
            while (tgt_valid[t] && n < SC + 1) begin   // Target released soon after
                @(negedge clk);
                check_val({row.name, " ready"}, 32'd0, 32'(src_ready[s]));
                n++;
            end
            if (tgt_valid[t]) begin
                note_timeout({row.name, " target valid stayed high after the abort"});
            end
            owner[t] = -1;
            repeat (2 * SC) begin
                @(negedge clk);
                check_val({row.name, " ready"}, 32'd0, 32'(src_ready[s]));
            end
        end else begin
            n = 0;
            while (!src_ready[s] && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (!src_ready[s]) begin
                note_timeout({row.name, " source ready never rose"});
                src_valid[s] = 1'b0;
                return;
            end
            owner[t] = -1;
            check_val({row.name, " rdata"}, off ^ TGT_KEY[t], src_rdata[row.src*DW +: DW]);
            check_val({row.name, " denied"}, 32'(off[2]), 32'(src_denied[s]));
            check_val({row.name, " corrupt"}, 32'(off[3]), 32'(src_corrupt[s]));
            repeat (2) begin
                @(negedge clk);
                check_val({row.name, " ready hold"}, 32'd1, 32'(src_ready[s]));
            end
            src_valid[s] = 1'b0;
            n = 0;
            while (src_ready[s] && n < SC + 1) begin
                @(negedge clk);
                n++;
            end
            if (src_ready[s]) begin
                note_timeout({row.name, " source ready did not fall after valid dropped"});
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int i;
        int g;
        void'($urandom(71));
        for (int t = 0; t < TC; t++) begin
            owner[t] = -1;
        end
        //      name              grp src rw    addr          wdata         strb  size  abort hold
        add_row("route_t0_read",   0, 0, 1'b0, 32'h0000_1234, 32'h0,        4'h0, 3'd2, 1'b0, 0);
        add_row("route_t1_write",  1, 1, 1'b1, 32'h4000_0A5C, 32'hDEAD_BEEF, 4'hF, 3'd2, 1'b0, 0);
        add_row("route_t2_write",  2, 2, 1'b1, 32'h8012_3408, 32'h0000_00A5, 4'h1, 3'd0, 1'b0, 0);
        add_row("route_t3_read",   3, 0, 1'b0, 32'hFFFF_FFFC, 32'h0,        4'h0, 3'd2, 1'b0, 0);
        add_row("contend_a",       4, 0, 1'b1, 32'h4000_0010, 32'h1111_2222, 4'h3, 3'd1, 1'b0, 0);
        add_row("contend_b",       4, 1, 1'b0, 32'h4000_0024, 32'h0,        4'h0, 3'd2, 1'b0, 0);
        add_row("contend_c",       4, 2, 1'b1, 32'h4000_0008, 32'h3333_4444, 4'hC, 3'd1, 1'b0, 0);
        add_row("parallel_t1",     5, 0, 1'b0, 32'h4000_0100, 32'h0,        4'h0, 3'd2, 1'b0, 0);
        add_row("parallel_t2",     5, 1, 1'b1, 32'h8000_020C, 32'h5555_6666, 4'hF, 3'd2, 1'b0, 0);
        add_row("parallel_t3",     5, 2, 1'b0, 32'hC000_0304, 32'h0,        4'h0, 3'd1, 1'b0, 0);
        add_row("abort_t2",        6, 2, 1'b0, 32'h8000_0040, 32'h0,        4'h0, 3'd2, 1'b1, 0);
        add_row("after_abort_t2",  7, 1, 1'b0, 32'h8000_004C, 32'h0,        4'h0, 3'd2, 1'b0, 0);
        add_row("abort_t0",        8, 0, 1'b1, 32'h0000_0100, 32'h7777_8888, 4'hF, 3'd2, 1'b1, 1);
        add_row("after_abort_t0",  9, 2, 1'b0, 32'h0000_010C, 32'h0,        4'h0, 3'd2, 1'b0, 0);
        add_row("abort_contend",  10, 0, 1'b0, 32'hC000_0010, 32'h0,        4'h0, 3'd2, 1'b1, 0);
        add_row("serve_contend",  10, 1, 1'b1, 32'hC000_0018, 32'h9999_AAAA, 4'h6, 3'd1, 1'b0, 0);

        repeat (2) @(negedge clk);                    // Two clocks in reset
        reset = 1'b0;
        check_val("reset_tgt_valid", 32'd0, 32'(tgt_valid));
        check_val("reset_src_ready", 32'd0, 32'(src_ready));

        i = 0;
        while (i < rows.size()) begin
            g = rows[i].grp;
            while (i < rows.size()) begin
                if (rows[i].grp != g) begin
                    break;
                end
                begin
                    automatic int k = i;
                    fork
                        run_txn(k);
                    join_none
                end
                i++;
            end
            wait fork;                                // Whole group done
            @(negedge clk);
        end

        check_val("parallel_targets", 32'd1, 32'(seen_three));
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== logic/p_switch_top.sv ====
`timescale 1ns/1ps

module p_switch_top #(
    parameter int SOURCE_COUNT = 3
) (
    input  logic                                           clk,
    input  logic                                           reset,

    // Source side
    input  logic [SOURCE_COUNT-1:0]                        src_valid,
    input  logic [SOURCE_COUNT-1:0]                        src_rw,
    input  logic [SOURCE_COUNT*switch_map_pkg::ADDR_W-1:0] src_addr,
    input  logic [SOURCE_COUNT*switch_txn_pkg::DATA_W-1:0] src_wdata,
    input  logic [SOURCE_COUNT*switch_txn_pkg::STRB_W-1:0] src_wstrb,
    input  logic [SOURCE_COUNT*switch_txn_pkg::SIZE_W-1:0] src_size,
    output logic [SOURCE_COUNT-1:0]                        src_ready,
    output logic [SOURCE_COUNT*switch_txn_pkg::DATA_W-1:0] src_rdata,
    output logic [SOURCE_COUNT-1:0]                        src_denied,
    output logic [SOURCE_COUNT-1:0]                        src_corrupt,

    // Target side
    input  logic [switch_map_pkg::TARGET_COUNT-1:0]        tgt_ready,
    input  logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::DATA_W-1:0] tgt_rdata,
    input  logic [switch_map_pkg::TARGET_COUNT-1:0]        tgt_denied,
    input  logic [switch_map_pkg::TARGET_COUNT-1:0]        tgt_corrupt,
    output logic [switch_map_pkg::TARGET_COUNT-1:0]        tgt_valid,
    output logic [switch_map_pkg::TARGET_COUNT-1:0]        tgt_rw,
    output logic [switch_map_pkg::TARGET_COUNT*switch_map_pkg::ADDR_W-1:0] tgt_addr,
    output logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::DATA_W-1:0] tgt_wdata,
    output logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::STRB_W-1:0] tgt_wstrb,
    output logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::SIZE_W-1:0] tgt_size
);

    // Source index width, at least one bit for a single source
    localparam int SRC_ID_W = (SOURCE_COUNT > 1) ? $clog2(SOURCE_COUNT) : 1;

    slot_if #(.SRC_ID_W(SRC_ID_W)) slot_bus ();  // Visited source, decode to later stages
    done_if                        done_bus ();  // Completion, execute to return

    //////////////////////////////
    // Stage instances
    //////////////////////////////

    source_decode #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .SRC_ID_W     (SRC_ID_W)
    ) decode_i (
        .clk       (clk),
        .reset     (reset),
        .src_valid (src_valid),
        .src_rw    (src_rw),
        .src_addr  (src_addr),
        .src_wdata (src_wdata),
        .src_wstrb (src_wstrb),
        .src_size  (src_size),
        .slot      (slot_bus.decode_mp)
    );

    switch_execute #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .SRC_ID_W     (SRC_ID_W)
    ) execute_i (
        .clk         (clk),
        .reset       (reset),
        .slot        (slot_bus.exec_mp),
        .resp        (done_bus.exec_mp),
        .tgt_ready   (tgt_ready),
        .tgt_rdata   (tgt_rdata),
        .tgt_denied  (tgt_denied),
        .tgt_corrupt (tgt_corrupt),
        .tgt_valid   (tgt_valid),
        .tgt_rw      (tgt_rw),
        .tgt_addr    (tgt_addr),
        .tgt_wdata   (tgt_wdata),
        .tgt_wstrb   (tgt_wstrb),
        .tgt_size    (tgt_size)
    );

    response_return #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .SRC_ID_W     (SRC_ID_W)
    ) return_i (
        .clk         (clk),
        .reset       (reset),
        .slot        (slot_bus.result_mp),
        .resp        (done_bus.result_mp),
        .src_ready   (src_ready),
        .src_rdata   (src_rdata),
        .src_denied  (src_denied),
        .src_corrupt (src_corrupt)
    );

endmodule

// ==== logic/response_return.sv ====
`timescale 1ns/1ps

module response_return #(
    parameter int SOURCE_COUNT = 1,
    parameter int SRC_ID_W     = 1
) (
    input  logic                                           clk,
    input  logic                                           reset,
    slot_if.result_mp                                      slot,
    done_if.result_mp                                      resp,
    output logic [SOURCE_COUNT-1:0]                        src_ready,
    output logic [SOURCE_COUNT*switch_txn_pkg::DATA_W-1:0] src_rdata,
    output logic [SOURCE_COUNT-1:0]                        src_denied,
    output logic [SOURCE_COUNT-1:0]                        src_corrupt
);

    localparam int DATA_W = switch_txn_pkg::DATA_W;

    logic [SRC_ID_W-1:0] vis_id;      // Source visited now
    int                  lane;        // Same, as a lane number
    logic                release_src; // Source dropped valid, end the hold phase

    assign vis_id      = slot.src_id;
    assign lane        = int'(vis_id);
    assign release_src = !slot.valid;

    // Execute stage must not regrant or abort a source still in hold
    assign resp.held   = src_ready[vis_id];

    //////////////////////////////
    // Ready per source
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            src_ready <= '0;
        end else if (resp.done) begin
            src_ready[vis_id] <= 1'b1;   // Held until the source lets go
        end else if (release_src) begin
            src_ready[vis_id] <= 1'b0;
        end
    end

    //////////////////////////////
    // Response payload
    //////////////////////////////

    // Done implies valid, so capture and clear never meet
    always_ff @(posedge clk) begin
        if (resp.done) begin
            src_rdata[lane*DATA_W +: DATA_W] <= resp.rdata;
            src_denied[vis_id]               <= resp.denied;
            src_corrupt[vis_id]              <= resp.corrupt;
        end else if (release_src) begin
            src_rdata[lane*DATA_W +: DATA_W] <= '0;
            src_denied[vis_id]               <= 1'b0;
            src_corrupt[vis_id]              <= 1'b0;
        end
    end

endmodule

// ==== logic/switch_execute.sv ====
`timescale 1ns/1ps

module switch_execute #(
    parameter int SOURCE_COUNT = 1,
    parameter int SRC_ID_W     = 1
) (
    input  logic                                                   clk,
    input  logic                                                   reset,
    slot_if.exec_mp                                                slot,
    done_if.exec_mp                                                resp,

    // Target side, flat vectors indexed by target
    input  logic [switch_map_pkg::TARGET_COUNT-1:0]                tgt_ready,
    input  logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::DATA_W-1:0] tgt_rdata,
    input  logic [switch_map_pkg::TARGET_COUNT-1:0]                tgt_denied,
    input  logic [switch_map_pkg::TARGET_COUNT-1:0]                tgt_corrupt,
    output logic [switch_map_pkg::TARGET_COUNT-1:0]                tgt_valid,
    output logic [switch_map_pkg::TARGET_COUNT-1:0]                tgt_rw,
    output logic [switch_map_pkg::TARGET_COUNT*switch_map_pkg::ADDR_W-1:0] tgt_addr,
    output logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::DATA_W-1:0] tgt_wdata,
    output logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::STRB_W-1:0] tgt_wstrb,
    output logic [switch_map_pkg::TARGET_COUNT*switch_txn_pkg::SIZE_W-1:0] tgt_size
);

    localparam int ADDR_W = switch_map_pkg::ADDR_W;
    localparam int DATA_W = switch_txn_pkg::DATA_W;
    localparam int STRB_W = switch_txn_pkg::STRB_W;
    localparam int SIZE_W = switch_txn_pkg::SIZE_W;

    //////////////////////////////
    // Per-source bookkeeping
    //////////////////////////////

    logic [SOURCE_COUNT-1:0] assigned;                         // Source owns a target
    switch_map_pkg::region_t tgt_idx [SOURCE_COUNT];           // Target taken at grant

    logic [SRC_ID_W-1:0]     vis_id;      // Source visited now
    switch_map_pkg::region_t vis_region;  // Target its address points to
    switch_map_pkg::region_t stored;      // Target it was granted earlier
    int                      new_t;       // Lane of the requested target
    int                      old_t;       // Lane of the stored target
    logic                    vis_assigned;
    logic                    do_grant;
    logic                    do_done;
    logic                    do_abort;
    switch_map_pkg::addr_u   grant_addr;  // Address handed to the target

    assign vis_id       = slot.src_id;
    assign vis_region   = slot.addr.fields.region;
    assign stored       = tgt_idx[vis_id];
    assign vis_assigned = assigned[vis_id];
    assign new_t        = int'(vis_region);
    assign old_t        = int'(stored);

    // New request, source idle and its target free
    assign do_grant = slot.valid && !resp.held && !vis_assigned && !tgt_valid[vis_region];

    // Stored target has answered, checked against the index kept at grant
    assign do_done  = slot.valid && !resp.held && vis_assigned &&
                      tgt_valid[stored] && tgt_ready[stored];

    // Source gave up before the answer came
    assign do_abort = !slot.valid && !resp.held && vis_assigned;

    // Region bits removed, target sees only its offset
    always_comb begin
        grant_addr.fields.region = '0;
        grant_addr.fields.offset = slot.addr.fields.offset;
    end

    //////////////////////////////
    // Control state
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tgt_valid <= '0;
            assigned  <= '0;
            for (int s = 0; s < SOURCE_COUNT; s++) begin
                tgt_idx[s] <= '0;
            end
        end else begin
            if (do_grant) begin
                tgt_valid[vis_region] <= 1'b1;       // Target sees request next clock
                assigned[vis_id]      <= 1'b1;
                tgt_idx[vis_id]       <= vis_region; // Remember where it went
            end
            if (do_done || do_abort) begin
                tgt_valid[stored]     <= 1'b0;       // Release the target
                assigned[vis_id]      <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Target request registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (do_grant) begin
            tgt_rw[new_t]                    <= slot.rw;
            tgt_addr[new_t*ADDR_W +: ADDR_W] <= grant_addr.word;
            tgt_wdata[new_t*DATA_W +: DATA_W] <= slot.wdata;
            tgt_wstrb[new_t*STRB_W +: STRB_W] <= slot.wstrb;
            tgt_size[new_t*SIZE_W +: SIZE_W]  <= slot.size;
        end
    end

    // Response of the stored target, taken by the return stage on done
    assign resp.done    = do_done;
    assign resp.rdata   = tgt_rdata[old_t*DATA_W +: DATA_W];
    assign resp.denied  = tgt_denied[stored];
    assign resp.corrupt = tgt_corrupt[stored];

endmodule

// ==== logic/source_decode.sv ====
`timescale 1ns/1ps

module source_decode #(
    parameter int SOURCE_COUNT = 1,
    parameter int SRC_ID_W     = 1
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [SOURCE_COUNT-1:0]                        src_valid,
    input  logic [SOURCE_COUNT-1:0]                        src_rw,
    input  logic [SOURCE_COUNT*switch_map_pkg::ADDR_W-1:0] src_addr,
    input  logic [SOURCE_COUNT*switch_txn_pkg::DATA_W-1:0] src_wdata,
    input  logic [SOURCE_COUNT*switch_txn_pkg::STRB_W-1:0] src_wstrb,
    input  logic [SOURCE_COUNT*switch_txn_pkg::SIZE_W-1:0] src_size,
    slot_if.decode_mp                                      slot
);

    localparam int ADDR_W = switch_map_pkg::ADDR_W;
    localparam int DATA_W = switch_txn_pkg::DATA_W;
    localparam int STRB_W = switch_txn_pkg::STRB_W;
    localparam int SIZE_W = switch_txn_pkg::SIZE_W;

    logic [SRC_ID_W-1:0] ptr;        // Round-robin pointer, one source per clock
    int                  sel;        // Pointer as a lane number

    //////////////////////////////
    // Round-robin pointer
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr <= '0;
        end else if (ptr == SRC_ID_W'(SOURCE_COUNT - 1)) begin
            ptr <= '0;                           // Wrap after the last source
        end else begin
            ptr <= ptr + 1'b1;
        end
    end

    //////////////////////////////
    // Source selection
    //////////////////////////////

    assign sel = int'(ptr);

    always_comb begin
        slot.src_id = ptr;
        slot.valid  = src_valid[sel];
        slot.rw     = src_rw[sel];
        // Address goes out as the union so later stages see region and offset
        slot.addr.fields.region = src_addr[sel*ADDR_W + switch_map_pkg::OFFSET_W +:
                                           switch_map_pkg::REGION_W];
        slot.addr.fields.offset = src_addr[sel*ADDR_W +: switch_map_pkg::OFFSET_W];
        slot.wdata  = src_wdata[sel*DATA_W +: DATA_W];
        slot.wstrb  = src_wstrb[sel*STRB_W +: STRB_W];
        slot.size   = src_size[sel*SIZE_W +: SIZE_W]; // Passed through untouched
    end

endmodule

// ==== logic/switch_ifc.sv ====
`timescale 1ns/1ps

//////////////////////////////
// Visited source slot
//////////////////////////////

// Fields of the source that the round-robin pointer looks at this cycle
interface slot_if #(
    parameter int SRC_ID_W = 1
);
    logic [SRC_ID_W-1:0]               src_id;   // Visited source
    logic                              valid;    // Its request level
    logic                              rw;       // Read/write
    switch_map_pkg::addr_u             addr;     // Full source address
    logic [switch_txn_pkg::DATA_W-1:0] wdata;    // Write data
    logic [switch_txn_pkg::STRB_W-1:0] wstrb;    // Byte strobes
    logic [switch_txn_pkg::SIZE_W-1:0] size;     // Request size

    // Pointer and selection side
    modport decode_mp (
        output src_id, valid, rw, addr, wdata, wstrb, size
    );

    // Grant, completion and abort logic
    modport exec_mp (
        input src_id, valid, rw, addr, wdata, wstrb, size
    );

    // Response side only cares who is visited and whether it still asks
    modport result_mp (
        input src_id, valid
    );
endinterface

//////////////////////////////
// Completion path
//////////////////////////////

// Everything here refers to the source currently visited
interface done_if;
    logic                              done;     // Stored target finished, released now
    logic [switch_txn_pkg::DATA_W-1:0] rdata;    // Read data of that target
    logic                              denied;   // Access refused by target
    logic                              corrupt;  // Data flagged as corrupt
    logic                              held;     // Source ready already set

    modport exec_mp (
        output done, rdata, denied, corrupt,
        input  held
    );

    modport result_mp (
        input  done, rdata, denied, corrupt,
        output held
    );
endinterface

// ==== logic/switch_txn_pkg.sv ====
package switch_txn_pkg;

    //////////////////////////////
    // Transaction payload widths
    //////////////////////////////

    parameter int DATA_W = 32;         // Read and write data word
    parameter int STRB_W = DATA_W / 8; // One strobe per byte lane
    parameter int SIZE_W = 3;          // Log2 of bytes per beat

endpackage

// ==== logic/switch_map_pkg.sv ====
package switch_map_pkg;

    //////////////////////////////
    // Address map geometry
    //////////////////////////////

    parameter int ADDR_W       = 32;              // Source address width
    parameter int REGION_W     = 2;               // Top bits that pick a target
    parameter int TARGET_COUNT = 2 ** REGION_W;   // One target per region
    parameter int OFFSET_W     = ADDR_W - REGION_W; // Address seen by a target

    typedef logic [REGION_W-1:0] region_t;        // Target index
    typedef logic [OFFSET_W-1:0] offset_t;        // Address inside a region

    // One address word, read flat or split into region and offset
    typedef union packed {
        logic [ADDR_W-1:0] word;                  // Plain address
        struct packed {
            region_t region;                      // Upper bits, target select
            offset_t offset;                      // Lower bits, forwarded to target
        } fields;
    } addr_u;

endpackage
